/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT      ?= --lint-only --timing --assert
TOP       ?= trap_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/trap_pkg.sv
rtl/trap_decode.sv
rtl/trap_manager.sv
rtl/trap_result.sv
rtl/trap_unit.sv
sim/trap_unit_props.sv
sim/trap_unit_tb.sv

/* rtl/trap_decode.sv */
// Flags traps on a 4-byte aligned PC only (no C extension); one event per instr_valid_i strobe
`timescale 1ns/10ps

module trap_decode import trap_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Issued instruction
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] instr_pc_i,

    // Registered trap event and its return PC
    output trap_event_t     event_o,
    output logic [XLEN-1:0] event_pc_o
);

    // --------------------
    // Classification
    // --------------------

    logic [6:0]  opcode;
    logic        legal_opcode;
    logic        is_system;
    logic        is_ecall;
    logic        is_ebreak;
    logic        is_wfi;
    logic        misaligned;
    logic        illegal;
    trap_event_t event_d;

    assign opcode = instr_i[6:0];

    // Only the eleven RV32I major opcodes are accepted
    always_comb begin
        case (opcode)
            OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
            OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE, OPCODE_OP_IMM,
            OPCODE_OP, OPCODE_MISC_MEM, OPCODE_SYSTEM: legal_opcode = 1'b1;
            default:                                   legal_opcode = 1'b0;
        endcase
    end

    // SYSTEM words are matched in full, so CSR accesses fall into illegal here
    assign is_system = (opcode == OPCODE_SYSTEM);
    assign is_ecall  = (instr_i == INSTR_ECALL);
    assign is_ebreak = (instr_i == INSTR_EBREAK);
    assign is_wfi    = (instr_i == INSTR_WFI);

    assign misaligned = |instr_pc_i[1:0];
    assign illegal    = !legal_opcode || (is_system && !(is_ecall || is_ebreak || is_wfi));

    // Priority chain, the misaligned PC beats every other cause
    always_comb begin
        event_d = '0;

        if (misaligned) begin
            event_d.exception = 1'b1;
            event_d.cause     = CAUSE_INSTR_MISALIGNED;
        end else if (illegal) begin
            event_d.exception = 1'b1;
            event_d.cause     = CAUSE_ILLEGAL;
        end else if (is_ebreak) begin
            event_d.exception = 1'b1;
            event_d.cause     = CAUSE_BREAKPOINT;
        end else if (is_ecall) begin
            event_d.exception = 1'b1;
            event_d.cause     = CAUSE_ECALL_M;
        end else if (is_wfi) begin
            // WFI is carried as an exception with sleep set and a zero cause
            event_d.exception = 1'b1;
            event_d.sleep     = 1'b1;
            event_d.cause     = CAUSE_INSTR_MISALIGNED;
        end
    end

    // --------------------
    // Event register
    // --------------------

    // The event lives for exactly one cycle, so a trap never fires twice
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            event_o <= '0;
        end else if (instr_valid_i) begin
            event_o <= event_d;
        end else begin
            event_o <= '0;
        end
    end

    // Return PC is held until the next issued instruction
    // WFI resumes at the following instruction once woken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            event_pc_o <= '0;
        end else if (instr_valid_i) begin
            event_pc_o <= is_wfi && !misaligned ? instr_pc_i + XLEN'(4) : instr_pc_i;
        end
    end

endmodule : trap_decode

/* rtl/trap_manager.sv */
// Interrupt must drop before the end of the ACK cycle; no nesting and no masking of interrupts
`timescale 1ns/10ps

module trap_manager import trap_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Trap sources
    input  logic        interrupt_i,
    input  trap_event_t event_i,

    // Pipeline control
    output logic        flush_o,
    output logic        stall_o,
    output logic        int_ack_o,
    output logic        trap_o
);

    // --------------------
    // State register
    // --------------------

    // CLEAR_CYCLE is never entered, it only falls back to IDLE
    typedef enum logic [1:0] {
        IDLE,
        ACK_CYCLE,
        CLEAR_CYCLE,
        WAIT_WAKE_UP
    } fsm_state_t;

    fsm_state_t state_q;
    fsm_state_t state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next state and outputs
    // --------------------

    always_comb begin
        // Every strobe is low unless a state raises it
        state_d   = state_q;
        flush_o   = 1'b0;
        stall_o   = 1'b0;
        int_ack_o = 1'b0;
        trap_o    = 1'b0;

        case (state_q)
            IDLE: begin
                // An interrupt wins over any event in the same cycle
                if (interrupt_i) begin
                    flush_o = 1'b1;
                    trap_o  = 1'b1;
                    state_d = ACK_CYCLE;
                end else if (event_i.exception) begin
                    if (event_i.sleep) begin
                        // WFI freezes the core but is not a taken trap
                        stall_o = 1'b1;
                        state_d = WAIT_WAKE_UP;
                    end else begin
                        // Synchronous trap, the handler is fetched right away
                        flush_o = 1'b1;
                        trap_o  = 1'b1;
                    end
                end
            end

            // Tell the controller the interrupt was taken, handler is already in flight
            ACK_CYCLE: begin
                int_ack_o = 1'b1;
                state_d   = IDLE;
            end

            // Core sleeps until the interrupt line rises
            WAIT_WAKE_UP: begin
                stall_o = 1'b1;
                if (interrupt_i) begin
                    flush_o = 1'b1;
                    trap_o  = 1'b1;
                    state_d = ACK_CYCLE;
                end
            end

            CLEAR_CYCLE: begin
                state_d = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule : trap_manager

/* rtl/trap_pkg.sv */
// Shared trap types for RV32 machine mode only; instruction encodings assume no C extension
package trap_pkg;

    // --------------------
    // Exception codes
    // --------------------

    // Synchronous exception codes from the privileged spec, machine mode only
    typedef enum logic [4:0] {
        CAUSE_INSTR_MISALIGNED = 5'd0,
        CAUSE_ILLEGAL          = 5'd2,
        CAUSE_BREAKPOINT       = 5'd3,
        CAUSE_ECALL_M          = 5'd11
    } trap_cause_e;

    // The external interrupt shares code 11 with ECALL, so it lives outside the enum
    // It is only meaningful when the interrupt bit of mcause is set
    parameter trap_cause_e CAUSE_EXT_INT = CAUSE_ECALL_M;

    // --------------------
    // Trap event
    // --------------------

    // One event per issued instruction, produced by decode
    typedef struct packed {
        logic        exception;
        logic        sleep;
        trap_cause_e cause;
    } trap_event_t;

    // --------------------
    // Encodings
    // --------------------

    // Full SYSTEM words recognised by decode
    parameter logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    parameter logic [31:0] INSTR_EBREAK = 32'h0010_0073;
    parameter logic [31:0] INSTR_WFI    = 32'h1050_0073;

    // Legal RV32I major opcodes, anything else decodes as illegal
    parameter logic [6:0] OPCODE_LUI      = 7'b0110111;
    parameter logic [6:0] OPCODE_AUIPC    = 7'b0010111;
    parameter logic [6:0] OPCODE_JAL      = 7'b1101111;
    parameter logic [6:0] OPCODE_JALR     = 7'b1100111;
    parameter logic [6:0] OPCODE_BRANCH   = 7'b1100011;
    parameter logic [6:0] OPCODE_LOAD     = 7'b0000011;
    parameter logic [6:0] OPCODE_STORE    = 7'b0100011;
    parameter logic [6:0] OPCODE_OP_IMM   = 7'b0010011;
    parameter logic [6:0] OPCODE_OP       = 7'b0110011;
    parameter logic [6:0] OPCODE_MISC_MEM = 7'b0001111;
    parameter logic [6:0] OPCODE_SYSTEM   = 7'b1110011;

endpackage : trap_pkg

/* rtl/trap_result.sv */
// Direct mtvec mode only; mcause assumes XLEN of at least 8 so the code field fits below the MSB
`timescale 1ns/10ps

module trap_result import trap_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // From the manager and the interrupt controller
    input  logic            trap_i,
    input  logic            interrupt_i,

    // From decode
    input  trap_event_t     event_i,
    input  logic [XLEN-1:0] event_pc_i,

    // CSR write port for mtvec
    input  logic            mtvec_we_i,
    input  logic [XLEN-1:0] mtvec_i,

    // Redirect to the handler
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_pc_o,

    // Trap CSRs
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o
);

    // --------------------
    // mtvec
    // --------------------

    logic [XLEN-1:0] mtvec_q;

    // Mode bits are tied to zero, which selects direct mode
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_q <= '0;
        end else if (mtvec_we_i) begin
            mtvec_q <= {mtvec_i[XLEN-1:2], 2'b00};
        end
    end

    // --------------------
    // Cause encoding
    // --------------------

    logic [XLEN-1:0] mcause_d;

    // A trap taken while the interrupt line is high is always the interrupt,
    // since the manager gives it priority in every state that can trap
    always_comb begin
        mcause_d           = '0;
        mcause_d[XLEN-1]   = interrupt_i;
        if (interrupt_i) begin
            mcause_d[4:0] = CAUSE_EXT_INT;
        end else begin
            mcause_d[4:0] = event_i.cause;
        end
    end

    // --------------------
    // Capture on a taken trap
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mepc_o   <= '0;
            mcause_o <= '0;
        end else if (trap_i) begin
            mepc_o   <= event_pc_i;
            mcause_o <= mcause_d;
        end
    end

    // --------------------
    // Redirect
    // --------------------

    // Pulse follows trap_i by one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= trap_i;
        end
    end

    // Vector is sampled with the trap, so a mtvec write in that cycle takes effect later
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            redirect_pc_o <= '0;
        end else if (trap_i) begin
            redirect_pc_o <= mtvec_q;
        end
    end

endmodule : trap_result

/* rtl/trap_unit.sv */
// No back-pressure: the environment must not issue instructions while stall_o is high
`timescale 1ns/10ps

module trap_unit import trap_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Issued instruction
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] instr_pc_i,

    // Interrupt controller
    input  logic            interrupt_i,
    output logic            int_ack_o,

    // CSR write of mtvec
    input  logic            mtvec_we_i,
    input  logic [XLEN-1:0] mtvec_i,

    // Pipeline control
    output logic            flush_o,
    output logic            stall_o,
    output logic            trap_o,

    // Fetch redirect
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_pc_o,

    // Trap CSRs
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o
);

    // --------------------
    // Internal wiring
    // --------------------

    // Decode output feeds both the manager and the result stage
    trap_event_t     trap_event;
    logic [XLEN-1:0] trap_event_pc;

    trap_decode #(
        .XLEN (XLEN)
    ) u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_pc_i    (instr_pc_i),
        .event_o       (trap_event),
        .event_pc_o    (trap_event_pc)
    );

    // The manager sees no PC, only the event flags and the interrupt line
    trap_manager u_manager (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .interrupt_i (interrupt_i),
        .event_i     (trap_event),
        .flush_o     (flush_o),
        .stall_o     (stall_o),
        .int_ack_o   (int_ack_o),
        .trap_o      (trap_o)
    );

    trap_result #(
        .XLEN (XLEN)
    ) u_result (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .trap_i           (trap_o),
        .interrupt_i      (interrupt_i),
        .event_i          (trap_event),
        .event_pc_i       (trap_event_pc),
        .mtvec_we_i       (mtvec_we_i),
        .mtvec_i          (mtvec_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause_o)
    );

endmodule : trap_unit

/* sim/trap_unit_props.sv */
// Covers manager strobes only; every property is disabled while rst_n_i is low
`timescale 1ns/10ps

module trap_unit_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic interrupt_i,
    input logic flush_o,
    input logic stall_o,
    input logic int_ack_o,
    input logic trap_o
);

    // --------------------
    // Strobe relations
    // --------------------

    // A taken trap always discards the younger instructions
    a_trap_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        trap_o |-> flush_o)
        else $error("trap_o raised without flush_o");

    // An interrupt trap is acknowledged in the very next cycle
    a_ack_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (trap_o && interrupt_i) |=> int_ack_o)
        else $error("int_ack_o missing one cycle after an interrupt trap");

    // And an acknowledge never shows up without that trap one cycle before
    a_ack_origin: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        int_ack_o |-> $past(trap_o && interrupt_i))
        else $error("int_ack_o raised without a preceding interrupt trap");

    // The core is awake again by the time the interrupt is acknowledged
    a_no_stall_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(stall_o && int_ack_o))
        else $error("stall_o and int_ack_o high together");

endmodule : trap_unit_props

bind trap_manager trap_unit_props u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .interrupt_i (interrupt_i),
    .flush_o     (flush_o),
    .stall_o     (stall_o),
    .int_ack_o   (int_ack_o),
    .trap_o      (trap_o)
);

/* sim/trap_unit_tb.sv */
// Runs trap_unit at XLEN 32 only; the first mismatch ends the run and no instructions issue in stall
`timescale 1ns/10ps

module trap_unit_tb import trap_pkg::*; ();

    localparam int XLEN           = 32;
    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk_i;
    logic            rst_n_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] instr_pc_i;
    logic            interrupt_i;
    logic            mtvec_we_i;
    logic [XLEN-1:0] mtvec_i;
    logic            flush_o;
    logic            stall_o;
    logic            int_ack_o;
    logic            trap_o;
    logic            redirect_valid_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic [XLEN-1:0] mepc_o;
    logic [XLEN-1:0] mcause_o;

    integer          seed;
    int              cycle_count;
    logic [31:0]     exp_vector;
    logic [31:0]     last_ret_pc;
    logic [6:0]      legal_ops [10];

    trap_unit #(
        .XLEN (XLEN)
    ) u_trap_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .instr_pc_i       (instr_pc_i),
        .interrupt_i      (interrupt_i),
        .int_ack_o        (int_ack_o),
        .mtvec_we_i       (mtvec_we_i),
        .mtvec_i          (mtvec_i),
        .flush_o          (flush_o),
        .stall_o          (stall_o),
        .trap_o           (trap_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause_o)
    );

    // --------------------
    // Clock and watchdog
    // --------------------

    always #2 clk_i = ~clk_i;

    // The whole test sequence needs well under two hundred cycles
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    // --------------------
    // Helpers
    // --------------------

    // Returns 1 ns after the rising edge, where inputs change
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Combinational outputs have settled 2 ns after the edge
    task automatic settle();
        #1;
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        assert (act === exp) else begin
            $display("ERROR %s %s: expected %b, actual %b", test, what, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compare_word(input string test, input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s %s: expected %h, actual %h", test, what, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Direct mode keeps only the word-aligned part of the written base
    task automatic write_mtvec(input logic [31:0] value);
        next_cycle();
        mtvec_we_i = 1'b1;
        mtvec_i    = value;
        next_cycle();
        mtvec_we_i = 1'b0;
        exp_vector = {value[31:2], 2'b00};
    endtask

    task automatic random_pc(output logic [31:0] pc);
        pc      = $random(seed);
        pc[1:0] = 2'b00;
    endtask

    // Issue one trapping instruction and follow it to the redirect
    task automatic take_exception(input string test, input logic [31:0] instr,
                                  input logic [31:0] pc, input logic [4:0] cause);
        next_cycle();
        instr_valid_i = 1'b1;
        instr_i       = instr;
        instr_pc_i    = pc;
        // The event is registered at this edge and the trap follows in the same cycle
        next_cycle();
        instr_valid_i = 1'b0;
        settle();
        check_flag(test, "trap_o", 1'b1, trap_o);
        check_flag(test, "flush_o", 1'b1, flush_o);
        check_flag(test, "stall_o", 1'b0, stall_o);
        check_flag(test, "int_ack_o", 1'b0, int_ack_o);
        next_cycle();
        settle();
        check_flag(test, "redirect_valid_o", 1'b1, redirect_valid_o);
        check_flag(test, "trap_o after capture", 1'b0, trap_o);
        compare_word(test, "redirect_pc_o", exp_vector, redirect_pc_o);
        compare_word(test, "mepc_o", pc, mepc_o);
        compare_word(test, "mcause_o", {27'd0, cause}, mcause_o);
        next_cycle();
        settle();
        check_flag(test, "redirect_valid_o drop", 1'b0, redirect_valid_o);
        last_ret_pc = pc;
    endtask

    // Caller sits at the drive point of the cycle that carries the interrupt
    task automatic raise_interrupt(input string test, input logic [31:0] ret_pc,
                                   input logic asleep);
        interrupt_i = 1'b1;
        settle();
        check_flag(test, "trap_o", 1'b1, trap_o);
        check_flag(test, "flush_o", 1'b1, flush_o);
        check_flag(test, "int_ack_o early", 1'b0, int_ack_o);
        check_flag(test, "stall_o at wake", asleep, stall_o);
        // The controller drops its request inside the acknowledge cycle
        next_cycle();
        interrupt_i = 1'b0;
        settle();
        check_flag(test, "int_ack_o", 1'b1, int_ack_o);
        check_flag(test, "trap_o in ack cycle", 1'b0, trap_o);
        check_flag(test, "stall_o in ack cycle", 1'b0, stall_o);
        check_flag(test, "redirect_valid_o", 1'b1, redirect_valid_o);
        compare_word(test, "redirect_pc_o", exp_vector, redirect_pc_o);
        compare_word(test, "mepc_o", ret_pc, mepc_o);
        compare_word(test, "mcause_o", {1'b1, 26'd0, 5'd11}, mcause_o);
        next_cycle();
        settle();
        check_flag(test, "int_ack_o drop", 1'b0, int_ack_o);
        check_flag(test, "redirect_valid_o drop", 1'b0, redirect_valid_o);
        check_flag(test, "trap_o after ack", 1'b0, trap_o);
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic reset_and_legal();
        logic [31:0] pc;
        logic [31:0] word;
        int          idx;
        int          i;
        check_flag("reset", "flush_o", 1'b0, flush_o);
        check_flag("reset", "stall_o", 1'b0, stall_o);
        check_flag("reset", "int_ack_o", 1'b0, int_ack_o);
        check_flag("reset", "trap_o", 1'b0, trap_o);
        check_flag("reset", "redirect_valid_o", 1'b0, redirect_valid_o);
        compare_word("reset", "redirect_pc_o", 32'd0, redirect_pc_o);
        compare_word("reset", "mepc_o", 32'd0, mepc_o);
        compare_word("reset", "mcause_o", 32'd0, mcause_o);
        // None of the back-to-back legal instructions may trap
        for (i = 0; i < 24; i++) begin
            random_pc(pc);
            word = $random(seed);
            idx  = int'({$random(seed)} % 32'd10);
            next_cycle();
            instr_valid_i = 1'b1;
            instr_i       = {word[31:7], legal_ops[idx]};
            instr_pc_i    = pc;
            settle();
            check_flag("legal", "trap_o", 1'b0, trap_o);
            check_flag("legal", "redirect_valid_o", 1'b0, redirect_valid_o);
        end
        next_cycle();
        instr_valid_i = 1'b0;
        settle();
        check_flag("legal", "trap_o last", 1'b0, trap_o);
        next_cycle();
        settle();
        check_flag("legal", "redirect_valid_o last", 1'b0, redirect_valid_o);
    endtask

    task automatic exception_causes();
        logic [31:0] pc;
        logic [31:0] base;
        base      = $random(seed);
        base[1:0] = 2'b11;
        write_mtvec(base);
        random_pc(pc);
        take_exception("ecall", INSTR_ECALL, pc, 5'd11);
        random_pc(pc);
        take_exception("ebreak", INSTR_EBREAK, pc, 5'd3);
        random_pc(pc);
        take_exception("illegal", 32'h0000_007F, pc, 5'd2);
        // Misaligned must win over the ECALL it carries
        random_pc(pc);
        pc[1] = 1'b1;
        take_exception("misaligned", INSTR_ECALL, pc, 5'd0);
    endtask

    task automatic external_interrupt();
        next_cycle();
        raise_interrupt("interrupt", last_ret_pc, 1'b0);
    endtask

    task automatic wfi_sleep_wake();
        logic [31:0] pc;
        int          idle;
        int          i;
        random_pc(pc);
        idle = 2 + int'({$random(seed)} % 32'd12);
        next_cycle();
        instr_valid_i = 1'b1;
        instr_i       = INSTR_WFI;
        instr_pc_i    = pc;
        next_cycle();
        instr_valid_i = 1'b0;
        settle();
        check_flag("wfi", "stall_o", 1'b1, stall_o);
        check_flag("wfi", "trap_o", 1'b0, trap_o);
        check_flag("wfi", "flush_o", 1'b0, flush_o);
        for (i = 0; i < idle; i++) begin
            next_cycle();
            settle();
            check_flag("wfi", "stall_o asleep", 1'b1, stall_o);
            check_flag("wfi", "trap_o asleep", 1'b0, trap_o);
            check_flag("wfi", "redirect_valid_o asleep", 1'b0, redirect_valid_o);
        end
        // Wake-up resumes after the WFI itself
        next_cycle();
        raise_interrupt("wfi", pc + 32'd4, 1'b1);
    endtask

    task automatic interrupt_priority();
        logic [31:0] pc;
        random_pc(pc);
        next_cycle();
        instr_valid_i = 1'b1;
        instr_i       = INSTR_ECALL;
        instr_pc_i    = pc;
        // The ECALL event is registered while the interrupt arrives
        next_cycle();
        instr_valid_i = 1'b0;
        raise_interrupt("priority", pc, 1'b0);
    endtask

    // --------------------
    // Sequence
    // --------------------

    initial begin
        seed          = 98;
        cycle_count   = 0;
        exp_vector    = '0;
        last_ret_pc   = '0;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        instr_pc_i    = '0;
        interrupt_i   = 1'b0;
        mtvec_we_i    = 1'b0;
        mtvec_i       = '0;
        legal_ops     = '{OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH,
                          OPCODE_LOAD, OPCODE_STORE, OPCODE_OP_IMM, OPCODE_OP, OPCODE_MISC_MEM};

        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        settle();

        reset_and_legal();
        exception_causes();
        external_interrupt();
        wfi_sleep_wake();
        interrupt_priority();

        $display("No errors");
        $finish;
    end

endmodule : trap_unit_tb
